//--- ccu_mem_arb.sv
// Round-robin arbiter onto the shared memory port, tags each read with its source and routes R by ID
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_mem_arb (
  input  logic            clk_i,
  input  logic            rst_i,
  ccu_rd_if.slave         src_i [`CCU_NUM_MST+1],
  output logic            mem_arvalid_o,
  input  logic            mem_arready_i,
  output ccu_pkg::addr_t  mem_araddr_o,
  output ccu_pkg::src_t   mem_arid_o,
  input  logic            mem_rvalid_i,
  output logic            mem_rready_o,
  input  ccu_pkg::data_t  mem_rdata_i,
  input  ccu_pkg::src_t   mem_rid_i,
  input  ccu_pkg::rresp_e mem_rresp_i
);
  import ccu_pkg::*;

  // Masters first, the snoop controller takes the last slot
  localparam int num_src = `CCU_NUM_MST + 1;

  logic [num_src-1:0]  arvalid_a, rready_a;
  addr_t [num_src-1:0] araddr_a;

  logic  lock_q;      // Grant held while memory stalls
  src_t  lock_idx_q;
  src_t  rr_q;        // Last source granted
  src_t  pick_idx, gnt_idx;
  logic  pick_valid;
  logic  ar_hs;

  for (genvar i = 0; i < num_src; i++) begin : gen_src
    assign arvalid_a[i] = src_i[i].arvalid;
    assign araddr_a[i]  = src_i[i].araddr;
    assign rready_a[i]  = src_i[i].rready;

    assign src_i[i].arready = ar_hs && (gnt_idx == src_t'(i));
    assign src_i[i].rvalid  = mem_rvalid_i && (mem_rid_i == src_t'(i));
    assign src_i[i].rdata   = mem_rdata_i;
    assign src_i[i].rresp   = mem_rresp_i;
  end

  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = '0;
    // Lowest requester overall, used when nothing sits above the pointer
    for (int i = num_src - 1; i >= 0; i--) begin
      if (arvalid_a[i]) begin
        pick_valid = 1'b1;
        pick_idx   = src_t'(i);
      end
    end
    // Lowest requester above the last grant wins
    for (int i = num_src - 1; i >= 0; i--) begin
      if (arvalid_a[i] && (i > int'(rr_q))) pick_idx = src_t'(i);
    end
  end

  assign gnt_idx       = lock_q ? lock_idx_q : pick_idx;
  assign mem_arvalid_o = lock_q | pick_valid;
  assign mem_araddr_o  = araddr_a[gnt_idx];
  assign mem_arid_o    = gnt_idx;  // ID is the source index
  assign ar_hs         = mem_arvalid_o & mem_arready_i;

  // Unknown IDs are drained so memory never hangs
  assign mem_rready_o = (int'(mem_rid_i) < num_src) ? rready_a[mem_rid_i] : 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      rr_q       <= src_t'(num_src - 1);  // Source 0 first after reset
    end else begin
      lock_q <= mem_arvalid_o & ~mem_arready_i;
      if (mem_arvalid_o && !mem_arready_i) lock_idx_q <= gnt_idx;
      if (ar_hs) rr_q <= gnt_idx;
    end
  end

  a_ar_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_arvalid_o && !mem_arready_i |=>
      mem_arvalid_o && $stable(mem_araddr_o) && $stable(mem_arid_o));

endmodule

//--- ccu_params.svh
// Master count and bus widths of the coherent read interconnect, included by every RTL file
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// Number of cache masters sharing the memory
`define CCU_NUM_MST 2

`define CCU_ADDR_W 32  // Address width
`define CCU_DATA_W 32  // Data width

// Source tag covers every master plus the snoop controller
`define CCU_SRC_W 2

`endif

//--- ccu_pkg.sv
// Shared types of the coherent read interconnect, imported by the interface and the RTL modules
`include "ccu_params.svh"

package ccu_pkg;

  localparam int mst_idx_w = (`CCU_NUM_MST > 1) ? $clog2(`CCU_NUM_MST) : 1;

  typedef logic [`CCU_ADDR_W-1:0] addr_t;
  typedef logic [`CCU_DATA_W-1:0] data_t;
  typedef logic [`CCU_SRC_W-1:0]  src_t;     // Memory ID, index of the source
  typedef logic [mst_idx_w-1:0]   mst_idx_t;

  // AXI encoding of the read response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } rresp_e;

  typedef enum logic {
    ROUTE_DIRECT,  // Non-shareable, straight to memory
    ROUTE_SNOOP    // Shareable, through the snoop controller
  } route_e;

  typedef enum logic [2:0] {
    SNP_IDLE,
    SNP_AC,      // Snoop address out to the peers
    SNP_CR,      // Collect snoop responses
    SNP_MEM_AR,  // Miss, read memory
    SNP_MEM_R,
    SNP_RESP     // Hit, return peer data
  } snp_state_e;

endpackage

//--- ccu_port_demux.sv
// Per-master router that sends a read to the direct or the snoop path and returns its response
`timescale 1ns/1ps

module ccu_port_demux (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            m_arvalid_i,
  input  ccu_pkg::addr_t  m_araddr_i,
  input  logic            m_arshare_i,
  output logic            m_arready_o,
  output logic            m_rvalid_o,
  input  logic            m_rready_i,
  output ccu_pkg::data_t  m_rdata_o,
  output ccu_pkg::rresp_e m_rresp_o,
  ccu_rd_if.master        direct_o,
  ccu_rd_if.master        snoop_o
);
  import ccu_pkg::*;

  route_e route_d, route_q;
  addr_t  addr_q;
  logic   busy_q;     // One read in flight
  logic   ar_pend_q;  // Request not yet taken by the chosen path
  logic   arready_q;
  logic   on_snoop;
  logic   ar_hs, path_ar_hs, r_hs;

  assign route_d  = m_arshare_i ? ROUTE_SNOOP : ROUTE_DIRECT;
  assign on_snoop = (route_q == ROUTE_SNOOP);

  assign m_arready_o = arready_q;
  assign ar_hs       = m_arvalid_i & arready_q;

  // Request goes to the recorded path only
  assign direct_o.arvalid = ar_pend_q & ~on_snoop;
  assign snoop_o.arvalid  = ar_pend_q & on_snoop;
  assign direct_o.araddr  = addr_q;
  assign snoop_o.araddr   = addr_q;

  assign path_ar_hs = on_snoop ? (snoop_o.arvalid & snoop_o.arready)
                               : (direct_o.arvalid & direct_o.arready);

  // Response taken only from the recorded path
  assign direct_o.rready = busy_q & ~on_snoop & m_rready_i;
  assign snoop_o.rready  = busy_q & on_snoop & m_rready_i;

  assign m_rvalid_o = busy_q & (on_snoop ? snoop_o.rvalid : direct_o.rvalid);
  assign m_rdata_o  = on_snoop ? snoop_o.rdata : direct_o.rdata;
  assign m_rresp_o  = on_snoop ? snoop_o.rresp : direct_o.rresp;

  assign r_hs = m_rvalid_o & m_rready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      ar_pend_q <= 1'b0;
      arready_q <= 1'b0;
      route_q   <= ROUTE_DIRECT;
    end else begin
      arready_q <= (~busy_q & ~ar_hs) | r_hs;  // Reopens in the cycle after the R beat
      if (ar_hs) begin
        busy_q    <= 1'b1;
        ar_pend_q <= 1'b1;
        route_q   <= route_d;
      end else begin
        if (path_ar_hs) ar_pend_q <= 1'b0;
        if (r_hs) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) addr_q <= m_araddr_i;
  end

  // The path that was not chosen must stay silent on R
  a_resp_path: assert property (@(posedge clk_i) disable iff (rst_i)
    (direct_o.rvalid | snoop_o.rvalid) |->
      busy_q && (on_snoop ? !direct_o.rvalid : !snoop_o.rvalid));

endmodule

//--- ccu_rd_if.sv
// Single-beat AR/R link between the demuxes, the snoop controller and the memory arbiter
`timescale 1ns/1ps

interface ccu_rd_if;
  import ccu_pkg::*;

  // Request side
  logic   arvalid;
  logic   arready;
  addr_t  araddr;

  // Response side, data and response travel as one beat
  logic   rvalid;
  logic   rready;
  data_t  rdata;
  rresp_e rresp;

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

//--- ccu_snoop_ctrl.sv
// Snoop controller that serializes shareable reads, snoops the peer caches and falls back to memory
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_snoop_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_i,
  ccu_rd_if.slave                           req_i [`CCU_NUM_MST],
  ccu_rd_if.master                          mem_o,
  output logic           [`CCU_NUM_MST-1:0] snp_acvalid_o,
  input  logic           [`CCU_NUM_MST-1:0] snp_acready_i,
  output ccu_pkg::addr_t [`CCU_NUM_MST-1:0] snp_acaddr_o,
  input  logic           [`CCU_NUM_MST-1:0] snp_crvalid_i,
  output logic           [`CCU_NUM_MST-1:0] snp_crready_o,
  input  logic           [`CCU_NUM_MST-1:0] snp_crhit_i,
  input  ccu_pkg::data_t [`CCU_NUM_MST-1:0] snp_cddata_i
);
  import ccu_pkg::*;

  localparam int num_mst = `CCU_NUM_MST;

  snp_state_e state_q, state_d;

  mst_idx_t             req_idx_q;  // Requester of the read in progress
  mst_idx_t             rr_q;       // Last requester served
  mst_idx_t             sel_idx;
  logic                 sel_valid;
  logic [num_mst-1:0]   req_onehot;
  addr_t                addr_q;

  logic [num_mst-1:0]   ac_done_q, cr_done_q, cr_done_d;
  logic                 hit_q, hit_d;
  mst_idx_t             hit_idx_q, hit_idx_d;
  data_t                hit_data_q, hit_data_d;

  logic [num_mst-1:0]   arvalid_a, rready_a;
  addr_t [num_mst-1:0]  araddr_a;
  logic                 ar_hs, rvalid_req, r_hs;

  for (genvar i = 0; i < num_mst; i++) begin : gen_port
    assign arvalid_a[i] = req_i[i].arvalid;
    assign araddr_a[i]  = req_i[i].araddr;
    assign rready_a[i]  = req_i[i].rready;

    assign req_i[i].arready = (state_q == SNP_IDLE) && sel_valid && (sel_idx == mst_idx_t'(i));
    assign req_i[i].rvalid  = rvalid_req && (req_idx_q == mst_idx_t'(i));
    assign req_i[i].rdata   = (state_q == SNP_RESP) ? hit_data_q : mem_o.rdata;
    assign req_i[i].rresp   = (state_q == SNP_RESP) ? RESP_OKAY : mem_o.rresp;

    // The requester's own bit is preset, so it is never snooped
    assign snp_acvalid_o[i] = (state_q == SNP_AC) && !ac_done_q[i];
    assign snp_crready_o[i] = (state_q == SNP_CR) && !cr_done_q[i];
    assign snp_acaddr_o[i]  = addr_q;

    a_ac_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      snp_acvalid_o[i] && !snp_acready_i[i] |=> snp_acvalid_o[i]);
  end

  // Round-robin pick, first requester after the last one served
  always_comb begin
    int idx;
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int k = num_mst; k >= 1; k--) begin
      idx = (int'(rr_q) + k) % num_mst;
      if (arvalid_a[idx]) begin
        sel_valid = 1'b1;
        sel_idx   = mst_idx_t'(idx);
      end
    end
    req_onehot          = '0;
    req_onehot[sel_idx] = 1'b1;
  end

  assign ar_hs = (state_q == SNP_IDLE) && sel_valid;

  // Snoop responses, lowest hitting peer supplies the data
  always_comb begin
    cr_done_d  = cr_done_q;
    hit_d      = hit_q;
    hit_idx_d  = hit_idx_q;
    hit_data_d = hit_data_q;
    for (int i = num_mst - 1; i >= 0; i--) begin
      if (snp_crvalid_i[i] && snp_crready_o[i]) begin
        cr_done_d[i] = 1'b1;
        if (snp_crhit_i[i] && (!hit_q || mst_idx_t'(i) < hit_idx_q)) begin
          hit_d      = 1'b1;
          hit_idx_d  = mst_idx_t'(i);
          hit_data_d = snp_cddata_i[i];
        end
      end
    end
  end

  // Memory fallback on a miss
  assign mem_o.arvalid = (state_q == SNP_MEM_AR);
  assign mem_o.araddr  = addr_q;
  assign mem_o.rready  = (state_q == SNP_MEM_R) && rready_a[req_idx_q];

  assign rvalid_req = ((state_q == SNP_MEM_R) && mem_o.rvalid) || (state_q == SNP_RESP);
  assign r_hs       = rvalid_req && rready_a[req_idx_q];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SNP_IDLE:   if (ar_hs) state_d = SNP_AC;
      SNP_AC:     if (&(ac_done_q | (snp_acvalid_o & snp_acready_i))) state_d = SNP_CR;
      SNP_CR:     if (&cr_done_d) state_d = hit_d ? SNP_RESP : SNP_MEM_AR;
      SNP_MEM_AR: if (mem_o.arready) state_d = SNP_MEM_R;
      SNP_MEM_R,
      SNP_RESP:   if (r_hs) state_d = SNP_IDLE;
      default:    state_d = SNP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= SNP_IDLE;
      req_idx_q <= '0;
      rr_q      <= '0;
      ac_done_q <= '0;
      cr_done_q <= '0;
      hit_q     <= 1'b0;
      hit_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        req_idx_q <= sel_idx;
        rr_q      <= sel_idx;
        ac_done_q <= req_onehot;
        cr_done_q <= req_onehot;
        hit_q     <= 1'b0;
      end else begin
        ac_done_q <= ac_done_q | (snp_acvalid_o & snp_acready_i);
        cr_done_q <= cr_done_d;
        hit_q     <= hit_d;
        hit_idx_q <= hit_idx_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) addr_q <= araddr_a[sel_idx];
    hit_data_q <= hit_data_d;  // Only moves on a CR beat
  end

endmodule

//--- ccu_top.sv
// Top level of the coherent read interconnect, connects the masters, their snoop ports and memory
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_top (
  input  logic                               clk_i,
  input  logic                               rst_i,

  // Master read ports
  input  logic            [`CCU_NUM_MST-1:0] m_arvalid_i,
  output logic            [`CCU_NUM_MST-1:0] m_arready_o,
  input  ccu_pkg::addr_t  [`CCU_NUM_MST-1:0] m_araddr_i,
  input  logic            [`CCU_NUM_MST-1:0] m_arshare_i,
  output logic            [`CCU_NUM_MST-1:0] m_rvalid_o,
  input  logic            [`CCU_NUM_MST-1:0] m_rready_i,
  output ccu_pkg::data_t  [`CCU_NUM_MST-1:0] m_rdata_o,
  output ccu_pkg::rresp_e [`CCU_NUM_MST-1:0] m_rresp_o,

  // Snoop ports toward each cache
  output logic            [`CCU_NUM_MST-1:0] snp_acvalid_o,
  input  logic            [`CCU_NUM_MST-1:0] snp_acready_i,
  output ccu_pkg::addr_t  [`CCU_NUM_MST-1:0] snp_acaddr_o,
  input  logic            [`CCU_NUM_MST-1:0] snp_crvalid_i,
  output logic            [`CCU_NUM_MST-1:0] snp_crready_o,
  input  logic            [`CCU_NUM_MST-1:0] snp_crhit_i,
  input  ccu_pkg::data_t  [`CCU_NUM_MST-1:0] snp_cddata_i,

  // Shared memory, ID echoed on R
  output logic                               mem_arvalid_o,
  input  logic                               mem_arready_i,
  output ccu_pkg::addr_t                     mem_araddr_o,
  output ccu_pkg::src_t                      mem_arid_o,
  input  logic                               mem_rvalid_i,
  output logic                               mem_rready_o,
  input  ccu_pkg::data_t                     mem_rdata_i,
  input  ccu_pkg::src_t                      mem_rid_i,
  input  ccu_pkg::rresp_e                    mem_rresp_i
);

  ccu_rd_if mem_if [`CCU_NUM_MST+1] ();  // Direct paths, last one from the snoop controller
  ccu_rd_if snp_if [`CCU_NUM_MST] ();    // Shareable paths

  for (genvar i = 0; i < `CCU_NUM_MST; i++) begin : gen_demux
    ccu_port_demux i_demux (
      .clk_i       ( clk_i          ),
      .rst_i       ( rst_i          ),
      .m_arvalid_i ( m_arvalid_i[i] ),
      .m_araddr_i  ( m_araddr_i[i]  ),
      .m_arshare_i ( m_arshare_i[i] ),
      .m_arready_o ( m_arready_o[i] ),
      .m_rvalid_o  ( m_rvalid_o[i]  ),
      .m_rready_i  ( m_rready_i[i]  ),
      .m_rdata_o   ( m_rdata_o[i]   ),
      .m_rresp_o   ( m_rresp_o[i]   ),
      .direct_o    ( mem_if[i]      ),
      .snoop_o     ( snp_if[i]      )
    );
  end

  ccu_snoop_ctrl i_snoop_ctrl (
    .clk_i         ( clk_i                ),
    .rst_i         ( rst_i                ),
    .req_i         ( snp_if               ),
    .mem_o         ( mem_if[`CCU_NUM_MST] ),
    .snp_acvalid_o ( snp_acvalid_o        ),
    .snp_acready_i ( snp_acready_i        ),
    .snp_acaddr_o  ( snp_acaddr_o         ),
    .snp_crvalid_i ( snp_crvalid_i        ),
    .snp_crready_o ( snp_crready_o        ),
    .snp_crhit_i   ( snp_crhit_i          ),
    .snp_cddata_i  ( snp_cddata_i         )
  );

  ccu_mem_arb i_mem_arb (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .src_i         ( mem_if        ),
    .mem_arvalid_o ( mem_arvalid_o ),
    .mem_arready_i ( mem_arready_i ),
    .mem_araddr_o  ( mem_araddr_o  ),
    .mem_arid_o    ( mem_arid_o    ),
    .mem_rvalid_i  ( mem_rvalid_i  ),
    .mem_rready_o  ( mem_rready_o  ),
    .mem_rdata_i   ( mem_rdata_i   ),
    .mem_rid_i     ( mem_rid_i     ),
    .mem_rresp_i   ( mem_rresp_i   )
  );

endmodule

//--- files.f
+incdir+.
ccu_pkg.sv
ccu_rd_if.sv
ccu_port_demux.sv
ccu_snoop_ctrl.sv
ccu_mem_arb.sv
ccu_top.sv
tb_ccu.sv

//--- run_sim.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_ccu \
  --Mdir obj_dir -o tb_ccu > build.log 2>&1 &&
./obj_dir/tb_ccu | tee sim.log &&
grep -qx "All checks passed" sim.log &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED, see build.log and sim.log"; exit 1; }

//--- tb_ccu.sv
// Self-checking testbench for the coherent read interconnect and the top of the simulation build
`timescale 1ns/1ps
`include "ccu_params.svh"

module tb_ccu;
  import ccu_pkg::*;

  localparam int nm      = `CCU_NUM_MST;
  localparam int num_seq = 6;    // Entries applied one at a time before the parallel phase
  localparam int num_ent = 12;
  localparam int tmo     = 200;  // Cycles allowed per wait

  typedef struct packed {
    int    mst;
    addr_t addr;
    logic  share;
    logic  hit;        // Peer cache holds the line
    data_t peer_data;
    data_t exp_data;
    logic  mem_rd;     // Memory read expected
    logic  snoop;      // Snoop on the peer expected
  } entry_t;

  logic            clk_i = 1'b0;
  logic            rst_i;
  logic [nm-1:0]   m_arvalid_i, m_arshare_i, m_rready_i, m_arready_o, m_rvalid_o;
  addr_t [nm-1:0]  m_araddr_i;
  data_t [nm-1:0]  m_rdata_o;
  rresp_e [nm-1:0] m_rresp_o;
  logic [nm-1:0]   snp_acvalid_o, snp_crready_o;
  logic [nm-1:0]   snp_acready_i = '1;
  logic [nm-1:0]   snp_crvalid_i = '0;
  logic [nm-1:0]   snp_crhit_i = '0;
  addr_t [nm-1:0]  snp_acaddr_o;
  data_t [nm-1:0]  snp_cddata_i = '0;
  logic            mem_arvalid_o, mem_rready_o;
  logic            mem_arready_i = 1'b1;
  addr_t           mem_araddr_o;
  src_t            mem_arid_o;
  logic            mem_rvalid_i = 1'b0;
  data_t           mem_rdata_i = '0;
  src_t            mem_rid_i = '0;
  rresp_e          mem_rresp_i = RESP_OKAY;

  entry_t      tbl [num_ent];
  int          n_ent = 0;
  logic [31:0] lfsr_q = 32'h7a23_7dc3;
  int          val_errs = 0;
  int          tmo_errs = 0;

  addr_t         rd_addr_q [$];  // Memory reads waiting for their R beat
  src_t          rd_id_q [$];
  int            mem_cnt = 0;
  int            mem_delay = 0;
  logic          mem_r_taken = 1'b0;
  int            snoop_cnt [nm];
  addr_t         ac_addr [nm];    // Last snoop address seen per master
  logic [nm-1:0] ac_taken = '0;
  logic [nm-1:0] cr_taken = '0;
  int            cr_delay [nm];

  ccu_top dut (.*);

  always #20 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic data_t mem_word(input addr_t a);
    return a ^ 32'h5a5a_0000;
  endfunction

  // Hit table of master j, made of the entries whose peer is expected to hit
  function automatic int find_hit(input int j, input addr_t a);
    int idx;
    idx = -1;
    for (int e = 0; e < n_ent; e++) begin
      if (tbl[e].hit && tbl[e].mst != j && tbl[e].addr == a) idx = e;
    end
    return idx;
  endfunction

  function automatic void add_entry(input int mst, input addr_t addr, input logic share,
                                    input logic hit, input data_t peer_data);
    entry_t en;
    en.mst       = mst;
    en.addr      = addr;
    en.share     = share;
    en.hit       = hit;
    en.peer_data = peer_data;
    en.exp_data  = hit ? peer_data : mem_word(addr);
    en.mem_rd    = ~hit;
    en.snoop     = share;
    tbl[n_ent]   = en;
    n_ent++;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_resp(input string name, input rresp_e got, input rresp_e exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  // Handshakes are sampled on the rising edge and the models react on the falling edge
  always @(posedge clk_i) begin
    mem_r_taken = mem_rvalid_i & mem_rready_o;
    if (!rst_i && mem_arvalid_o && mem_arready_i) begin
      rd_addr_q.push_back(mem_araddr_o);
      rd_id_q.push_back(mem_arid_o);
      mem_cnt++;
    end
    for (int j = 0; j < nm; j++) begin
      ac_taken[j] = snp_acvalid_o[j] & snp_acready_i[j];
      cr_taken[j] = snp_crvalid_i[j] & snp_crready_o[j];
      if (ac_taken[j]) begin
        snoop_cnt[j]++;
        ac_addr[j] = snp_acaddr_o[j];
      end
    end
  end

  // Memory model with random AR stalls and in-order R beats after 1 to 4 cycles
  always @(negedge clk_i) begin
    mem_arready_i = (rand_bits(2) != 0);
    if (mem_rvalid_i && mem_r_taken) mem_rvalid_i = 1'b0;
    if (!mem_rvalid_i && rd_addr_q.size() > 0) begin
      if (mem_delay == 0) mem_delay = 1 + int'(rand_bits(2));
      mem_delay--;
      if (mem_delay == 0) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem_word(rd_addr_q[0]);
        mem_rid_i    = rd_id_q[0];  // ID echoed
        mem_rresp_i  = RESP_OKAY;
        rd_addr_q.delete(0);
        rd_id_q.delete(0);
      end
    end
  end

  // One snoop responder per master with random AC stalls
  always @(negedge clk_i) begin
    int idx;
    for (int j = 0; j < nm; j++) begin
      snp_acready_i[j] = (rand_bits(2) != 0);
      if (snp_crvalid_i[j] && cr_taken[j]) snp_crvalid_i[j] = 1'b0;
      if (ac_taken[j]) cr_delay[j] = 1 + int'(rand_bits(2));
      if (cr_delay[j] > 0) begin
        cr_delay[j]--;
        if (cr_delay[j] == 0) begin
          idx              = find_hit(j, ac_addr[j]);
          snp_crvalid_i[j] = 1'b1;
          snp_crhit_i[j]   = (idx >= 0);
          snp_cddata_i[j]  = (idx >= 0) ? tbl[idx].peer_data : ~ac_addr[j];  // Junk on a miss
        end
      end
    end
  end

  // One read on its master with random rready stalls
  task automatic run_read(input int e);
    int    m;
    int    t;
    logic  held_v;
    data_t held;
    m      = tbl[e].mst;
    held_v = 1'b0;
    held   = '0;
    @(negedge clk_i);
    m_arvalid_i[m] = 1'b1;
    m_araddr_i[m]  = tbl[e].addr;
    m_arshare_i[m] = tbl[e].share;
    for (t = 0; t < tmo; t++) begin
      @(posedge clk_i);
      if (m_arready_o[m]) break;
    end
    if (t == tmo) begin
      $display("Timeout: master %0d read of %h was never accepted", m, tbl[e].addr);
      tmo_errs++;
      @(negedge clk_i);
      m_arvalid_i[m] = 1'b0;
    end else begin
      for (t = 0; t < tmo; t++) begin
        @(negedge clk_i);
        m_arvalid_i[m] = 1'b0;
        m_rready_i[m]  = (rand_bits(2) != 0);  // Stall about one cycle in four
        @(posedge clk_i);
        if (held_v) begin
          check_count("m_rvalid_o", int'(m_rvalid_o[m]), 1);
          check_data("m_rdata_o", m_rdata_o[m], held);  // Must not move while stalled
        end
        if (m_rvalid_o[m] && m_rready_i[m]) break;
        held_v = m_rvalid_o[m];
        held   = m_rdata_o[m];
      end
      if (t == tmo) begin
        $display("Timeout: master %0d got no response for %h", m, tbl[e].addr);
        tmo_errs++;
      end else begin
        check_data("m_rdata_o", m_rdata_o[m], tbl[e].exp_data);
        check_resp("m_rresp_o", m_rresp_o[m], RESP_OKAY);
      end
    end
  endtask

  initial begin
    int m;
    int peer;
    int mem0;
    int req0;
    int peer0;
    int exp_snp [nm];
    rst_i       = 1'b1;
    m_arvalid_i = '0;
    m_arshare_i = '0;
    m_araddr_i  = '0;
    m_rready_i  = '0;

    add_entry(0, 32'h0000_1000, 1'b0, 1'b0, '0);
    add_entry(1, 32'h0000_2004, 1'b0, 1'b0, '0);
    add_entry(0, 32'h0000_3008, 1'b1, 1'b0, '0);
    add_entry(1, 32'h0000_400c, 1'b1, 1'b0, '0);
    add_entry(0, 32'h0000_5010, 1'b1, 1'b1, 32'hcafe_0001);
    add_entry(1, 32'h0000_6014, 1'b1, 1'b1, 32'hbeef_0002);
    add_entry(0, 32'h0001_0000, 1'b0, 1'b0, '0);
    add_entry(1, 32'h0001_1000, 1'b1, 1'b0, '0);
    add_entry(0, 32'h0001_2000, 1'b1, 1'b1, 32'h1234_5678);
    add_entry(1, 32'h0001_3000, 1'b0, 1'b0, '0);
    add_entry(0, 32'h0001_4000, 1'b1, 1'b0, '0);
    add_entry(1, 32'h0001_5000, 1'b1, 1'b1, 32'h8765_4321);

    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    @(posedge clk_i);
    check_count("m_rvalid_o", int'(m_rvalid_o), 0);
    check_count("snp_acvalid_o", int'(snp_acvalid_o), 0);
    check_count("snp_crready_o", int'(snp_crready_o), 0);
    check_count("mem_arvalid_o", int'(mem_arvalid_o), 0);

    for (int e = 0; e < num_seq; e++) begin
      m     = tbl[e].mst;
      peer  = 1 - m;
      mem0  = mem_cnt;
      req0  = snoop_cnt[m];
      peer0 = snoop_cnt[peer];
      run_read(e);
      check_count("memory read count", mem_cnt - mem0, int'(tbl[e].mem_rd));
      check_count("requester snoop count", snoop_cnt[m] - req0, 0);
      check_count("peer snoop count", snoop_cnt[peer] - peer0, int'(tbl[e].snoop));
      if (tbl[e].snoop) check_addr("snp_acaddr_o", ac_addr[peer], tbl[e].addr);
    end

    // Both masters at once with totals checked afterwards
    mem0 = mem_cnt;
    for (int j = 0; j < nm; j++) exp_snp[j] = snoop_cnt[j];
    for (int e = num_seq; e < num_ent; e++) begin
      mem0 = mem0 + int'(tbl[e].mem_rd);
      for (int j = 0; j < nm; j++) begin
        if (tbl[e].snoop && tbl[e].mst != j) exp_snp[j]++;
      end
    end
    fork
      begin
        for (int e = num_seq; e < num_ent; e++) begin
          if (tbl[e].mst == 0) run_read(e);
        end
      end
      begin
        for (int e = num_seq; e < num_ent; e++) begin
          if (tbl[e].mst == 1) run_read(e);
        end
      end
    join
    check_count("memory read count", mem_cnt, mem0);
    for (int j = 0; j < nm; j++) check_count("snoop count", snoop_cnt[j], exp_snp[j]);

    repeat (4) @(posedge clk_i);
    $display("Errors: %0d wrong values, %0d timeouts", val_errs, tmo_errs);
    if (val_errs == 0 && tmo_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
